// ==== Makefile ====
# Verilator build and run for the rename stage testbench

SOURCES := $(shell grep -v '^+' tb.f)

.PHONY: all run clean

all: run

# rebuilt only when a source, the header or the file list changes
obj_dir/Vrename_tb: tb.f $(SOURCES) hdl/rename_params.svh
	verilator --binary --timing -f tb.f --top-module rename_tb -o Vrename_tb

# pass or fail is decided from the log
run: obj_dir/Vrename_tb
	-./obj_dir/Vrename_tb > sim.log 2>&1
	cat sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== hdl/prf_free_list.sv ====
//////////////////////////////////////////////////
// physical tag free list
// bitmap, offers the two lowest free tags
//////////////////////////////////////////////////

`include "rename_params.svh"

module prf_free_list (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  consume1,       // slot 1 taken by rat
	input  logic                  consume2,       // slot 2 taken by rat
	input  rename_pkg::prf_mask_t recover_mask,   // dropped by mispredict
	input  rename_pkg::prf_mask_t released_mask,  // freed by commit
	output rename_pkg::prf_tag_t  alloc_tag1,     // lowest free tag
	output rename_pkg::prf_tag_t  alloc_tag2,     // second lowest
	output logic                  alloc_valid1,
	output logic                  alloc_valid2
);

	localparam rename_pkg::prf_tag_t null_tag = rename_pkg::prf_tag_t'(`RENAME_NULL_TAG);

	rename_pkg::prf_mask_t free_bits;     // one bit per free tag
	rename_pkg::prf_mask_t rest_bits;     // free bits minus slot 1
	rename_pkg::prf_mask_t consume_bits;
	rename_pkg::prf_mask_t n_free_bits;

	// priority encode, lowest set bit wins
	function automatic rename_pkg::prf_tag_t lowest_tag(input rename_pkg::prf_mask_t bits);
		rename_pkg::prf_tag_t tag;
		tag = '0;
		for (int i = `RENAME_PRF_SIZE-1; i >= 0; i--) begin
			if (bits[i])
				tag = rename_pkg::prf_tag_t'(i);
		end
		return tag;
	endfunction

	//////////////////////////////////////////////////
	// allocation slots
	//////////////////////////////////////////////////

	assign alloc_tag1   = lowest_tag(free_bits);
	assign alloc_valid1 = |free_bits;

	// hide slot 1, then search again
	assign rest_bits    = free_bits & ~(rename_pkg::prf_mask_t'(1) << alloc_tag1);
	assign alloc_tag2   = lowest_tag(rest_bits);
	assign alloc_valid2 = |rest_bits;

	//////////////////////////////////////////////////
	// bitmap update
	//////////////////////////////////////////////////

	always_comb begin
		consume_bits = '0;
		if (consume1)
			consume_bits[alloc_tag1] = 1'b1;
		if (consume2)
			consume_bits[alloc_tag2] = 1'b1;
	end

	always_comb begin
		n_free_bits = (free_bits & ~consume_bits) | recover_mask | released_mask;
		n_free_bits[null_tag] = 1'b0;       // never handed out
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `RENAME_PRF_SIZE; i++) begin
				// tags above the identity map start free
				free_bits[i] <= (i >= `RENAME_ARF_SIZE) && (i != `RENAME_NULL_TAG);
			end
		end else begin
			free_bits <= n_free_bits;
		end
	end

endmodule

// ==== hdl/rat.sv ====
//////////////////////////////////////////////////
// rename alias table
// speculative arf to prf map, two renames per cycle
//////////////////////////////////////////////////

`include "rename_params.svh"

module rat (
	input  logic                   clock,
	input  logic                   reset,
	// instruction 1
	input  logic                   inst1_enable,     // inst1 valid this cycle
	input  rename_pkg::arf_idx_t   opa_arf1,
	input  rename_pkg::arf_idx_t   opb_arf1,
	input  rename_pkg::arf_idx_t   dest_arf1,
	input  logic                   dest_rename1,     // dest needs a new tag
	input  logic                   opa_imm1,         // opa is an immediate
	input  logic                   opb_imm1,
	// instruction 2
	input  logic                   inst2_enable,
	input  rename_pkg::arf_idx_t   opa_arf2,
	input  rename_pkg::arf_idx_t   opb_arf2,
	input  rename_pkg::arf_idx_t   dest_arf2,
	input  logic                   dest_rename2,
	input  logic                   opa_imm2,
	input  logic                   opb_imm2,
	// recovery
	input  logic                   mispredict,       // single cycle pulse
	input  rename_pkg::map_table_t committed_map,    // from rrat
	// free list slots
	input  rename_pkg::prf_tag_t   alloc_tag1,       // lowest free tag
	input  rename_pkg::prf_tag_t   alloc_tag2,       // second lowest
	input  logic                   alloc_valid1,
	input  logic                   alloc_valid2,
	// results
	output rename_pkg::prf_tag_t   opa_tag1,
	output rename_pkg::prf_tag_t   opb_tag1,
	output rename_pkg::prf_tag_t   dest_tag1,
	output rename_pkg::prf_tag_t   opa_tag2,
	output rename_pkg::prf_tag_t   opb_tag2,
	output rename_pkg::prf_tag_t   dest_tag2,
	output logic                   halt1,            // no tag for inst1
	output logic                   halt2,
	output logic                   consume1,         // slot 1 taken
	output logic                   consume2,         // slot 2 taken
	output rename_pkg::prf_mask_t  recover_mask      // tags dropped by recovery
);

	localparam rename_pkg::arf_idx_t zero_reg = rename_pkg::arf_idx_t'(`RENAME_ZERO_REG);
	localparam rename_pkg::prf_tag_t null_tag = rename_pkg::prf_tag_t'(`RENAME_NULL_TAG);

	rename_pkg::map_table_t rat_reg;    // current speculative map
	rename_pkg::map_table_t n_rat_reg;
	logic need1;                        // inst1 wants a tag
	logic need2;
	logic go1;                          // inst1 renames this cycle
	logic go2;
	logic bypass_a2;                    // inst2 opa reads inst1 dest
	logic bypass_b2;

	// source lookup against the current map
	function automatic rename_pkg::prf_tag_t lookup(
		input logic                   imm,
		input rename_pkg::arf_idx_t   idx,
		input rename_pkg::map_table_t map
	);
		rename_pkg::prf_tag_t tag;
		if (imm)
			tag = '0;                   // immediates read tag 0
		else if (idx == zero_reg)
			tag = null_tag;
		else
			tag = map[idx];
		return tag;
	endfunction

	//////////////////////////////////////////////////
	// slot assignment and halts
	//////////////////////////////////////////////////

	assign need1 = inst1_enable & dest_rename1 & (dest_arf1 != zero_reg);
	assign need2 = inst2_enable & dest_rename2 & (dest_arf2 != zero_reg);

	// inst1 always takes slot 1, inst2 takes the next one left
	assign halt1 = ~mispredict & need1 & ~alloc_valid1;
	assign halt2 = ~mispredict & inst2_enable &
		(halt1 | (need2 & ~(need1 ? alloc_valid2 : alloc_valid1)));  // keep order

	assign go1 = ~mispredict & need1 & ~halt1;
	assign go2 = ~mispredict & need2 & ~halt2;

	assign consume1 = go1 | go2;        // first renamer takes slot 1
	assign consume2 = go1 & go2;

	assign dest_tag1 = go1 ? alloc_tag1 : null_tag;
	assign dest_tag2 = go2 ? (go1 ? alloc_tag2 : alloc_tag1) : null_tag;

	//////////////////////////////////////////////////
	// source tags
	//////////////////////////////////////////////////

	assign bypass_a2 = go1 & ~opa_imm2 & (opa_arf2 == dest_arf1);
	assign bypass_b2 = go1 & ~opb_imm2 & (opb_arf2 == dest_arf1);

	always_comb begin
		opa_tag1 = null_tag;
		opb_tag1 = null_tag;
		opa_tag2 = null_tag;
		opb_tag2 = null_tag;
		if (!mispredict) begin                    // null sources while recovering
			if (inst1_enable) begin
				opa_tag1 = lookup(opa_imm1, opa_arf1, rat_reg);
				opb_tag1 = lookup(opb_imm1, opb_arf1, rat_reg);
			end
			if (inst2_enable) begin
				opa_tag2 = bypass_a2 ? dest_tag1 : lookup(opa_imm2, opa_arf2, rat_reg);
				opb_tag2 = bypass_b2 ? dest_tag1 : lookup(opb_imm2, opb_arf2, rat_reg);
			end
		end
	end

	//////////////////////////////////////////////////
	// map update and recovery
	//////////////////////////////////////////////////

	always_comb begin
		n_rat_reg = rat_reg;
		if (go1)
			n_rat_reg[dest_arf1] = dest_tag1;
		if (go2)
			n_rat_reg[dest_arf2] = dest_tag2;     // inst2 wins on same dest
		if (mispredict)
			n_rat_reg = committed_map;            // back to committed state
	end

	// speculative tags the copy throws away
	always_comb begin
		recover_mask = '0;
		if (mispredict) begin
			for (int i = 0; i < `RENAME_ARF_SIZE; i++) begin
				if (rat_reg[i] != committed_map[i] && rat_reg[i] != null_tag)
					recover_mask[rat_reg[i]] = 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `RENAME_ARF_SIZE; i++) begin
				// identity map, zero reg on the null tag
				rat_reg[i] <= (i == `RENAME_ZERO_REG) ? null_tag : rename_pkg::prf_tag_t'(i);
			end
		end else begin
			rat_reg <= n_rat_reg;
		end
	end

endmodule

// ==== hdl/rename_params.svh ====
//////////////////////////////////////////////////
// rename stage sizes and special tags
//////////////////////////////////////////////////

`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// table sizes
`define RENAME_ARF_SIZE 32                      // architectural registers
`define RENAME_PRF_SIZE 64                      // physical tags

// special indices
`define RENAME_ZERO_REG (`RENAME_ARF_SIZE-1)    // hardwired zero, never renamed

// tag seen for the zero reg and on a mispredict cycle
// sits above the initial free range and is never allocated
`define RENAME_NULL_TAG (`RENAME_PRF_SIZE-1)

`endif

// ==== hdl/rename_pkg.sv ====
//////////////////////////////////////////////////
// rename package
// index, tag and map table types for the rename stage
//////////////////////////////////////////////////

`include "rename_params.svh"

package rename_pkg;

	// architectural register index
	typedef logic [$clog2(`RENAME_ARF_SIZE)-1:0] arf_idx_t;

	// physical register tag
	typedef logic [$clog2(`RENAME_PRF_SIZE)-1:0] prf_tag_t;

	// one tag per architectural register
	typedef prf_tag_t [`RENAME_ARF_SIZE-1:0] map_table_t;

	// one bit per physical tag, free and release bitmaps
	typedef logic [`RENAME_PRF_SIZE-1:0] prf_mask_t;

endpackage

// ==== hdl/rename_stage.sv ====
//////////////////////////////////////////////////
// rename stage top
// rat, rrat and free list for a two wide core
//////////////////////////////////////////////////

`include "rename_params.svh"

module rename_stage (
	input  logic                 clock,
	input  logic                 reset,
	// instruction 1
	input  logic                 inst1_enable,
	input  rename_pkg::arf_idx_t opa_arf1,
	input  rename_pkg::arf_idx_t opb_arf1,
	input  rename_pkg::arf_idx_t dest_arf1,
	input  logic                 dest_rename1,
	input  logic                 opa_imm1,
	input  logic                 opb_imm1,
	// instruction 2
	input  logic                 inst2_enable,
	input  rename_pkg::arf_idx_t opa_arf2,
	input  rename_pkg::arf_idx_t opb_arf2,
	input  rename_pkg::arf_idx_t dest_arf2,
	input  logic                 dest_rename2,
	input  logic                 opa_imm2,
	input  logic                 opb_imm2,
	input  logic                 mispredict,     // restore committed map
	// commits, in program order
	input  logic                 commit1_valid,
	input  rename_pkg::arf_idx_t commit1_arf,
	input  rename_pkg::prf_tag_t commit1_tag,
	input  logic                 commit2_valid,
	input  rename_pkg::arf_idx_t commit2_arf,
	input  rename_pkg::prf_tag_t commit2_tag,
	// rename results
	output rename_pkg::prf_tag_t opa_tag1,
	output rename_pkg::prf_tag_t opb_tag1,
	output rename_pkg::prf_tag_t dest_tag1,
	output rename_pkg::prf_tag_t opa_tag2,
	output rename_pkg::prf_tag_t opb_tag2,
	output rename_pkg::prf_tag_t dest_tag2,
	output logic                 halt1,
	output logic                 halt2
);

	rename_pkg::prf_tag_t   alloc_tag1;       // free list to rat
	rename_pkg::prf_tag_t   alloc_tag2;
	logic                   alloc_valid1;
	logic                   alloc_valid2;
	logic                   consume1;         // rat to free list
	logic                   consume2;
	rename_pkg::prf_mask_t  recover_mask;
	rename_pkg::prf_mask_t  released_mask;    // rrat to free list
	rename_pkg::map_table_t committed_map;    // rrat to rat

	rat u_rat (
		.clock, .reset,
		.inst1_enable, .opa_arf1, .opb_arf1, .dest_arf1, .dest_rename1, .opa_imm1, .opb_imm1,
		.inst2_enable, .opa_arf2, .opb_arf2, .dest_arf2, .dest_rename2, .opa_imm2, .opb_imm2,
		.mispredict, .committed_map,
		.alloc_tag1, .alloc_tag2, .alloc_valid1, .alloc_valid2,
		.opa_tag1, .opb_tag1, .dest_tag1, .opa_tag2, .opb_tag2, .dest_tag2,
		.halt1, .halt2, .consume1, .consume2, .recover_mask
	);

	rrat u_rrat (
		.clock, .reset,
		.commit1_valid, .commit1_arf, .commit1_tag,
		.commit2_valid, .commit2_arf, .commit2_tag,
		.committed_map, .released_mask
	);

	prf_free_list u_free_list (
		.clock, .reset,
		.consume1, .consume2, .recover_mask, .released_mask,
		.alloc_tag1, .alloc_tag2, .alloc_valid1, .alloc_valid2
	);

endmodule

// ==== hdl/rrat.sv ====
//////////////////////////////////////////////////
// retirement alias table
// committed map, two commits per cycle
//////////////////////////////////////////////////

`include "rename_params.svh"

module rrat (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   commit1_valid,    // older commit
	input  rename_pkg::arf_idx_t   commit1_arf,
	input  rename_pkg::prf_tag_t   commit1_tag,
	input  logic                   commit2_valid,    // younger commit
	input  rename_pkg::arf_idx_t   commit2_arf,
	input  rename_pkg::prf_tag_t   commit2_tag,
	output rename_pkg::map_table_t committed_map,    // registered table
	output rename_pkg::prf_mask_t  released_mask     // tags overwritten this cycle
);

	localparam rename_pkg::prf_tag_t null_tag = rename_pkg::prf_tag_t'(`RENAME_NULL_TAG);

	rename_pkg::map_table_t n_map;
	logic write1;                       // commit1 updates the table
	logic write2;

	// zero reg is never renamed, ignore commits to it
	assign write1 = commit1_valid & (commit1_arf != rename_pkg::arf_idx_t'(`RENAME_ZERO_REG));
	assign write2 = commit2_valid & (commit2_arf != rename_pkg::arf_idx_t'(`RENAME_ZERO_REG));

	always_comb begin
		n_map = committed_map;
		released_mask = '0;
		if (write1) begin
			released_mask[n_map[commit1_arf]] = 1'b1;   // old mapping freed
			n_map[commit1_arf] = commit1_tag;
		end
		if (write2) begin
			// reads after commit1, so a same-reg pair frees commit1's tag
			released_mask[n_map[commit2_arf]] = 1'b1;
			n_map[commit2_arf] = commit2_tag;
		end
		released_mask[null_tag] = 1'b0;                 // null tag never freed
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `RENAME_ARF_SIZE; i++) begin
				committed_map[i] <= (i == `RENAME_ZERO_REG) ? null_tag :
					rename_pkg::prf_tag_t'(i);
			end
		end else begin
			committed_map <= n_map;
		end
	end

endmodule

// ==== tb.f ====
+incdir+hdl
hdl/rename_pkg.sv
hdl/rat.sv
hdl/rrat.sv
hdl/prf_free_list.sv
hdl/rename_stage.sv
test/rename_tb.sv

// ==== test/rename_tb.sv ====
//////////////////////////////////////////////////
// rename stage testbench
// directed bundles checked against a map and free list model
//////////////////////////////////////////////////

`include "rename_params.svh"

module rename_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int zero_reg = `RENAME_ZERO_REG;
	localparam int null_tag = `RENAME_NULL_TAG;

	logic clock = 1'b0;
	logic reset = 1'b1;                              // held until 8 edges seen
	logic inst1_enable, dest_rename1, opa_imm1, opb_imm1;
	logic inst2_enable, dest_rename2, opa_imm2, opb_imm2;
	logic mispredict, commit1_valid, commit2_valid;
	rename_pkg::arf_idx_t opa_arf1, opb_arf1, dest_arf1;
	rename_pkg::arf_idx_t opa_arf2, opb_arf2, dest_arf2;
	rename_pkg::arf_idx_t commit1_arf, commit2_arf;
	rename_pkg::prf_tag_t commit1_tag, commit2_tag;
	rename_pkg::prf_tag_t opa_tag1, opb_tag1, dest_tag1;
	rename_pkg::prf_tag_t opa_tag2, opb_tag2, dest_tag2;
	logic halt1, halt2;

	int spec_map [`RENAME_ARF_SIZE];                 // model speculative map
	int comm_map [`RENAME_ARF_SIZE];                 // model committed map
	bit free_set [`RENAME_PRF_SIZE];                 // model free tags
	int seen_dest1;                                  // last sampled outputs
	int seen_dest2;
	bit seen_halt1;
	bit seen_halt2;

	rename_stage UUT (.*);

	always #10 clock = ~clock;

	initial begin
		repeat (8) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("tests failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_value(input string what, input int got, input int exp);
		assert (got == exp) else
			fail_run($sformatf("CHECK FAILED at %0t: %s got %0d, expected %0d",
				$time, what, got, exp));
	endtask

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	function automatic void init_model();
		for (int i = 0; i < `RENAME_ARF_SIZE; i++) begin
			spec_map[i] = (i == zero_reg) ? null_tag : i;   // identity after reset
			comm_map[i] = spec_map[i];
		end
		for (int t = 0; t < `RENAME_PRF_SIZE; t++)
			free_set[t] = (t >= `RENAME_ARF_SIZE) && (t != null_tag);
	endfunction

	function automatic int lowest_free(input int skip);
		for (int t = 0; t < `RENAME_PRF_SIZE; t++)
			if (free_set[t] && t != skip)
				return t;
		return -1;                                    // nothing left
	endfunction

	function automatic int free_count();
		int n;
		n = 0;
		for (int t = 0; t < `RENAME_PRF_SIZE; t++)
			n += int'(free_set[t]);
		return n;
	endfunction

	function automatic int exp_src(input logic imm, input int idx);
		if (imm)
			return 0;
		if (idx == zero_reg)
			return null_tag;
		return spec_map[idx];
	endfunction

	function automatic void model_commit(input int arf, input int tag);
		if (comm_map[arf] != null_tag)
			free_set[comm_map[arf]] = 1'b1;           // overwritten tag released
		comm_map[arf] = tag;
	endfunction

	function automatic void model_recover();
		for (int i = 0; i < `RENAME_ARF_SIZE; i++) begin
			if (spec_map[i] != comm_map[i] && spec_map[i] != null_tag)
				free_set[spec_map[i]] = 1'b1;         // dropped speculative tag
			spec_map[i] = comm_map[i];
		end
	endfunction

	function automatic int rand_reg();
		return int'($urandom_range(zero_reg - 1, 0));   // never the zero reg
	endfunction

	//////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////

	task automatic clear_inputs();
		{inst1_enable, dest_rename1, opa_imm1, opb_imm1} = '0;
		{inst2_enable, dest_rename2, opa_imm2, opb_imm2} = '0;
		{opa_arf1, opb_arf1, dest_arf1, opa_arf2, opb_arf2, dest_arf2} = '0;
		{mispredict, commit1_valid, commit2_valid} = '0;
		{commit1_arf, commit2_arf, commit1_tag, commit2_tag} = '0;
	endtask

	task automatic set_inst1(input int a, input int b, input int d, input logic ren);
		inst1_enable = 1'b1;
		opa_arf1 = rename_pkg::arf_idx_t'(a);
		opb_arf1 = rename_pkg::arf_idx_t'(b);
		dest_arf1 = rename_pkg::arf_idx_t'(d);
		dest_rename1 = ren;
	endtask

	task automatic set_inst2(input int a, input int b, input int d, input logic ren);
		inst2_enable = 1'b1;
		opa_arf2 = rename_pkg::arf_idx_t'(a);
		opb_arf2 = rename_pkg::arf_idx_t'(b);
		dest_arf2 = rename_pkg::arf_idx_t'(d);
		dest_rename2 = ren;
	endtask

	task automatic wait_reset_done();
		int cycles;
		cycles = 0;
		while (reset !== 1'b0) begin
			@(negedge clock);
			cycles++;
			if (cycles > 20)
				fail_run("reset was never released");
		end
	endtask

	// check one bundle just before the edge, then advance the model
	task automatic step_bundle();
		int t1;
		int t2;
		int e1;
		int e2;
		bit need1;
		bit need2;
		bit h1;
		bit h2;
		#5;                                           // outputs settled
		t1 = lowest_free(-1);
		t2 = lowest_free(t1);
		need1 = inst1_enable && dest_rename1 && int'(dest_arf1) != zero_reg;
		need2 = inst2_enable && dest_rename2 && int'(dest_arf2) != zero_reg;
		h1 = need1 && t1 < 0;
		h2 = inst2_enable && (h1 || (need2 && (need1 ? t2 : t1) < 0));   // order kept
		e1 = (need1 && !h1) ? t1 : -1;
		e2 = (need2 && !h2) ? ((e1 >= 0) ? t2 : t1) : -1;
		check_value("halt1", int'(halt1), int'(h1));
		check_value("halt2", int'(halt2), int'(h2));
		seen_halt1 = halt1;
		seen_halt2 = halt2;
		seen_dest1 = int'(dest_tag1);
		seen_dest2 = int'(dest_tag2);
		if (inst1_enable) begin
			check_value("opa_tag1", int'(opa_tag1), exp_src(opa_imm1, int'(opa_arf1)));
			check_value("opb_tag1", int'(opb_tag1), exp_src(opb_imm1, int'(opb_arf1)));
		end
		if (e1 >= 0)
			check_value("dest_tag1", seen_dest1, e1);
		if (inst2_enable) begin
			check_value("opa_tag2", int'(opa_tag2), (e1 >= 0 && !opa_imm2 &&
				opa_arf2 == dest_arf1) ? e1 : exp_src(opa_imm2, int'(opa_arf2)));
			check_value("opb_tag2", int'(opb_tag2), (e1 >= 0 && !opb_imm2 &&
				opb_arf2 == dest_arf1) ? e1 : exp_src(opb_imm2, int'(opb_arf2)));
		end
		if (e2 >= 0)
			check_value("dest_tag2", seen_dest2, e2);
		@(posedge clock);
		if (e1 >= 0) begin
			spec_map[dest_arf1] = e1;
			free_set[e1] = 1'b0;
		end
		if (e2 >= 0) begin
			spec_map[dest_arf2] = e2;                 // inst2 wins a shared dest
			free_set[e2] = 1'b0;
		end
		@(negedge clock);
		clear_inputs();
	endtask

	task automatic dual_rename();
		set_inst1(rand_reg(), rand_reg(), rand_reg(), 1'b1);
		set_inst2(rand_reg(), rand_reg(), rand_reg(), 1'b1);
		step_bundle();
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////

	task automatic test_reset_state();
		int r;
		r = rand_reg();
		set_inst1(r, zero_reg, r, 1'b1);
		set_inst2(rand_reg(), rand_reg(), zero_reg, 1'b0);
		opa_imm2 = 1'b1;                              // immediate reads tag 0
		step_bundle();
		check_value("first rename tag", seen_dest1, `RENAME_ARF_SIZE);
	endtask

	task automatic test_single_renames();
		int r1;
		int r2;
		r1 = rand_reg();
		r2 = rand_reg();
		set_inst1(rand_reg(), rand_reg(), r1, 1'b1);
		step_bundle();
		set_inst2(rand_reg(), rand_reg(), r2, 1'b1);  // inst2 alone takes slot 1
		step_bundle();
		set_inst1(r1, r2, 0, 1'b0);
		step_bundle();
	endtask

	task automatic test_dual_rename();
		int d1;
		int d3;
		d1 = rand_reg();
		d3 = rand_reg();
		set_inst1(rand_reg(), rand_reg(), d1, 1'b1);
		set_inst2(d1, rand_reg(), rand_reg(), 1'b1);  // opa bypassed from inst1
		step_bundle();
		set_inst1(rand_reg(), rand_reg(), d3, 1'b1);
		set_inst2(rand_reg(), d3, d3, 1'b1);
		step_bundle();
		set_inst1(d3, d1, 0, 1'b0);
		step_bundle();
	endtask

	task automatic test_exhaustion();
		int d1;
		int d2;
		while (free_count() > 2)
			dual_rename();
		if (free_count() == 2) begin
			set_inst1(rand_reg(), rand_reg(), rand_reg(), 1'b1);
			step_bundle();
		end
		dual_rename();                                // one tag left
		check_value("halt1 with one tag", int'(seen_halt1), 0);
		check_value("halt2 with one tag", int'(seen_halt2), 1);
		d1 = rand_reg();
		d2 = rand_reg();
		set_inst1(rand_reg(), rand_reg(), d1, 1'b1);
		set_inst2(rand_reg(), rand_reg(), d2, 1'b1);
		step_bundle();
		check_value("halt1 when empty", int'(seen_halt1), 1);
		check_value("halt2 when empty", int'(seen_halt2), 1);
		set_inst1(d1, d2, 0, 1'b0);                   // maps must be untouched
		step_bundle();
	endtask

	task automatic test_commit_recovery();
		int x;
		int y;
		int i;
		int start;
		int prev;
		x = -1;
		y = -1;
		start = rand_reg();
		for (int k = 0; k < zero_reg; k++) begin
			i = (start + k) % zero_reg;
			if (spec_map[i] != comm_map[i] && x < 0)
				x = i;
			else if (spec_map[i] != comm_map[i] && y < 0)
				y = i;
		end
		if (y < 0)
			fail_run("fewer than two renamed registers available to commit");
		commit1_valid = 1'b1;
		commit1_arf = rename_pkg::arf_idx_t'(x);
		commit1_tag = rename_pkg::prf_tag_t'(spec_map[x]);
		commit2_valid = 1'b1;
		commit2_arf = rename_pkg::arf_idx_t'(y);
		commit2_tag = rename_pkg::prf_tag_t'(spec_map[y]);
		@(posedge clock);
		model_commit(x, spec_map[x]);
		model_commit(y, spec_map[y]);
		@(negedge clock);
		clear_inputs();
		dual_rename();                                // released tags, lowest first
		set_inst1(rand_reg(), rand_reg(), rand_reg(), 1'b1);   // free list drained here
		set_inst2(rand_reg(), rand_reg(), rand_reg(), 1'b1);
		mispredict = 1'b1;
		#5;
		check_value("halt1 on mispredict", int'(halt1), 0);
		check_value("halt2 on mispredict", int'(halt2), 0);
		check_value("opa_tag1 on mispredict", int'(opa_tag1), null_tag);
		check_value("opb_tag1 on mispredict", int'(opb_tag1), null_tag);
		check_value("opa_tag2 on mispredict", int'(opa_tag2), null_tag);
		check_value("opb_tag2 on mispredict", int'(opb_tag2), null_tag);
		@(posedge clock);
		model_recover();
		@(negedge clock);
		clear_inputs();
		for (int r = 0; r < zero_reg; r += 4) begin   // committed map everywhere
			set_inst1(r, r + 1, 0, 1'b0);
			set_inst2(r + 2, r + 3, 0, 1'b0);
			step_bundle();
		end
		prev = -1;
		for (int k = 0; k < 4 && free_count() >= 2; k++) begin
			dual_rename();
			check_value("ascending slot 1", int'(seen_dest1 > prev), 1);
			check_value("ascending slot 2", int'(seen_dest2 > seen_dest1), 1);
			prev = seen_dest2;
		end
	endtask

	initial begin
		void'($urandom(32'h10e0_82a5));
		clear_inputs();
		init_model();
		wait_reset_done();
		test_reset_state();
		test_single_renames();
		test_dual_rename();
		test_exhaustion();
		test_commit_recovery();
		$display("all tests passed");
		$finish;
	end

endmodule
